// File: proc.f
+incdir+tests
logic/procPkg.sv
logic/pipeReg.sv
logic/fetchStage.sv
logic/regFile.sv
logic/hazardUnit.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memoryStage.sv
logic/proc.sv
tests/procTb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = procTb
FILELIST = proc.f
OBJDIR   = obj_dir
BIN      = $(OBJDIR)/V$(TOP)
SOURCES  = $(wildcard logic/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJDIR)

// File: tests/procModel.svh
/* Instruction-level reference model of the core
   and random program generator */
`ifndef PROC_MODEL_SVH
`define PROC_MODEL_SVH

logic [15:0] prog      [256];
logic [15:0] modelMem  [256];
logic [15:0] modelRegs [8];
logic [18:0] expTrace  [$];
logic        modelErr;

function automatic int randBelow(input int n);
   return int'($unsigned($random(seed)) % n);
endfunction

function automatic bit isLegalOp(input logic [4:0] code);
   return code inside {opHalt, opNop, opJ, opAddi, opBeqz, opBnez, opSt, opLd, opLbi, opRtype};
endfunction

// Registers 0..3 only, so sources often hit a recent destination
function automatic logic [15:0] aluInstr(input int lbiRange);
   logic [2:0] ra;
   logic [2:0] rb;
   logic [2:0] rc;
   ra = 3'(randBelow(4));
   rb = 3'(randBelow(4));
   rc = 3'(randBelow(4));
   case (randBelow(3))
      0:       return {opRtype, ra, rb, rc, 2'(randBelow(4))};
      1:       return {opAddi, ra, rb, 5'(randBelow(32))};
      default: return {opLbi, ra, 8'(randBelow(lbiRange))};
   endcase
endfunction

// Bases in r0 and r1, data in r2 and r3
function automatic logic [15:0] memInstr();
   logic [2:0] base;
   logic [2:0] data;
   base = 3'(randBelow(2));
   data = 3'(2 + randBelow(2));
   case (randBelow(4))
      0:       return {opSt, base, data, 5'(randBelow(32))};
      1:       return {opLd, base, data, 5'(randBelow(32))};
      2:       return {opLbi, base, 8'(randBelow(256))};
      default: return aluInstr(256);
   endcase
endfunction

// Forward targets that never pass the final HALT
function automatic logic [15:0] ctrlInstr(input int idx);
   int room;
   room = progLen - 2 - idx;
   case (randBelow(4))
      0:       return {opBeqz, 3'(randBelow(4)), 8'(randBelow((room < 6 ? room : 6) + 1))};
      1:       return {opBnez, 3'(randBelow(4)), 8'(randBelow((room < 6 ? room : 6) + 1))};
      2:       return {opJ, 11'(randBelow((room < 4 ? room : 4) + 1))};
      default: return aluInstr(2);
   endcase
endfunction

function automatic void genProgram(input int kind);
   logic [4:0] badOp;
   for (int a = 0; a < 256; a++) begin
      // HALT everywhere else with the address in the low bits
      prog[a] = {opHalt, 3'b000, 8'(a)};
   end
   for (int i = 0; i < progLen - 1; i++) begin
      case (kind)
         kindMem:  prog[i] = memInstr();
         kindCtrl: prog[i] = ctrlInstr(i);
         kindMixed: begin
            case (randBelow(4))
               0:       prog[i] = aluInstr(256);
               1:       prog[i] = memInstr();
               2:       prog[i] = ctrlInstr(i);
               default: prog[i] = {opNop, 11'(randBelow(2048))};
            endcase
         end
         default:  prog[i] = aluInstr(256);
      endcase
   end
   if (kind == kindIllegal) begin
      badOp = 5'(randBelow(32));
      while (isLegalOp(badOp)) begin
         badOp = 5'(randBelow(32));
      end
      prog[progLen / 2] = {badOp, 11'(randBelow(2048))};
   end
endfunction

function automatic void writeReg(input logic [2:0] r, input logic [15:0] v);
   modelRegs[r] = v;
   expTrace.push_back({r, v});
endfunction

// Runs from PC 0 with zeroed registers; data memory carries over
function automatic void runModel();
   logic [15:0] ins;
   logic [15:0] a;
   logic [15:0] b;
   logic [15:0] addr;
   int          pc;
   int          steps;
   bit          done;
   for (int r = 0; r < 8; r++) begin
      modelRegs[r] = '0;
   end
   expTrace.delete();
   modelErr = 1'b0;
   pc = 0;
   steps = 0;
   done = 1'b0;
   while (!done && steps < 1024) begin
      ins = prog[pc % 256];
      a = modelRegs[ins[10:8]];
      b = modelRegs[ins[7:5]];
      addr = a + {{11{ins[4]}}, ins[4:0]};
      steps++;
      pc++;
      case (ins[15:11])
         opHalt:  done = 1'b1;
         opNop:   ;
         opJ:     pc = pc + int'($signed(ins[10:0]));
         opAddi:  writeReg(ins[7:5], addr);
         opBeqz:  pc = (a == 0) ? pc + int'($signed(ins[7:0])) : pc;
         opBnez:  pc = (a != 0) ? pc + int'($signed(ins[7:0])) : pc;
         opSt:    modelMem[addr[7:0]] = b;
         opLd:    writeReg(ins[7:5], modelMem[addr[7:0]]);
         opLbi:   writeReg(ins[10:8], {{8{ins[7]}}, ins[7:0]});
         opRtype: begin
            case (ins[1:0])
               fnAdd:   writeReg(ins[4:2], a + b);
               fnSub:   writeReg(ins[4:2], a - b);
               fnXor:   writeReg(ins[4:2], a ^ b);
               default: writeReg(ins[4:2], a & b);
            endcase
         end
         default: begin
            modelErr = 1'b1;
            done = 1'b1;
         end
      endcase
   end
endfunction

`endif

// File: tests/procTb.sv
/* Testbench for the pipelined core: random programs checked
   against an instruction-level model through the write-back trace */
`timescale 1ns/1ps
`default_nettype none

module procTb;

   import procPkg::*;

   localparam int          clkPeriod   = 100;
   localparam int          resetCycles = 8;
   localparam int          progLen     = 32;
   localparam int          numTests    = 6;
   localparam int          runLimit    = progLen * 10;
   localparam int          loadCycles  = resetCycles + 256;
   localparam int          watchCycles = (numTests + 1) * (loadCycles + runLimit);
   localparam logic [31:0] seedInit    = 32'h3939a1cd;

   localparam int kindAlu     = 0;
   localparam int kindMem     = 1;
   localparam int kindCtrl    = 2;
   localparam int kindMixed   = 3;
   localparam int kindIllegal = 4;

   integer      seed;
   logic        clk;
   logic        rstN;
   logic        loadEn;
   logic [7:0]  loadAddr;
   logic [15:0] loadInstr;
   logic        wbValid;
   logic [2:0]  wbReg;
   logic [15:0] wbData;
   logic        halted;
   logic        err;

   logic [18:0] gotTrace [$];
   int          haltedWb;
   int          errorCount;
   int          testsOk;
   int          testsBad;

   `include "procModel.svh"

   proc DUT (
      .clk       (clk),
      .rstN      (rstN),
      .loadEn    (loadEn),
      .loadAddr  (loadAddr),
      .loadInstr (loadInstr),
      .wbValid   (wbValid),
      .wbReg     (wbReg),
      .wbData    (wbData),
      .halted    (halted),
      .err       (err)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // Trace monitor sees the values from before each rising edge
   always @(posedge clk) begin
      if (rstN && wbValid) begin
         gotTrace.push_back({wbReg, wbData});
         if (halted) begin
            haltedWb++;
         end
      end
   end

   task automatic checkValue(input string testName, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
      if (expected !== actual) begin
         $display("CHECK FAILED %s %s: expected %0h actual %0h", testName, what,
                  expected, actual);
         errorCount++;
      end
   endtask

   // Program goes in while reset is held
   task automatic loadProgram();
      @(negedge clk);
      rstN = 1'b0;
      repeat (resetCycles) @(negedge clk);
      for (int a = 0; a < 256; a++) begin
         loadEn = 1'b1;
         loadAddr = 8'(a);
         loadInstr = prog[a];
         @(negedge clk);
      end
      loadEn = 1'b0;
      gotTrace.delete();
      haltedWb = 0;
      rstN = 1'b1;
   endtask

   task automatic checkRun(input string name);
      int cycles;
      int startErrors;
      int n;
      startErrors = errorCount;
      cycles = 0;
      while (!halted && cycles < runLimit) begin
         @(posedge clk);
         cycles++;
      end
      if (!halted) begin
         $display("ERROR %s: core did not halt within %0d cycles", name, runLimit);
         errorCount++;
      end
      // Late write-backs would show up in these cycles
      repeat (4) @(negedge clk);
      checkValue(name, "halted", 1, halted);
      checkValue(name, "err", modelErr, err);
      checkValue(name, "writes after halt", 0, haltedWb);
      checkValue(name, "trace length", expTrace.size(), gotTrace.size());
      n = (expTrace.size() < gotTrace.size()) ? expTrace.size() : gotTrace.size();
      for (int i = 0; i < n; i++) begin
         checkValue(name, $sformatf("reg of write %0d", i), expTrace[i][18:16],
                    gotTrace[i][18:16]);
         checkValue(name, $sformatf("data of write %0d", i), expTrace[i][15:0],
                    gotTrace[i][15:0]);
      end
      if (errorCount == startErrors) begin
         testsOk++;
         $display("test %-12s ok", name);
      end else begin
         testsBad++;
         $display("test %-12s FAILED", name);
      end
   endtask

   task automatic runTest(input string name, input int kind);
      genProgram(kind);
      runModel();
      loadProgram();
      checkRun(name);
   endtask

   initial begin
      seed = seedInit;
      clk = 1'b0;
      rstN = 1'b0;
      loadEn = 1'b0;
      loadAddr = '0;
      loadInstr = '0;
      haltedWb = 0;
      errorCount = 0;
      testsOk = 0;
      testsBad = 0;
      for (int a = 0; a < 256; a++) begin
         modelMem[a] = '0;
      end
      runTest("aluImm", kindAlu);
      runTest("loadStore", kindMem);
      runTest("control", kindCtrl);
      runTest("halt", kindMixed);
      runTest("illegal", kindIllegal);
      // Interrupted program has no stores, so data memory stays as modelled
      genProgram(kindAlu);
      loadProgram();
      repeat (progLen / 2) @(negedge clk);
      checkValue("resetMidRun", "halted before reset", 0, halted);
      runTest("resetMidRun", kindMem);
      $display("tests ok %0d, tests bad %0d, check errors %0d", testsOk, testsBad, errorCount);
      if (errorCount == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

   initial begin
      #(watchCycles * clkPeriod);
      $display("ERROR watchdog expired, the tests did not finish in time");
      $display("sim failed");
      $finish;
   end

endmodule

`default_nettype wire

// File: logic/proc.sv
/* Five-stage 16-bit pipelined core with a program load port
   and a write-back trace */
`timescale 1ns/1ps
`default_nettype none

module proc (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          loadEn,
   input  logic [procPkg::memAddrW-1:0]  loadAddr,
   input  logic [procPkg::dataW-1:0]     loadInstr,
   output logic                          wbValid,
   output logic [procPkg::regAddrW-1:0]  wbReg,
   output logic [procPkg::dataW-1:0]     wbData,
   output logic                          halted,
   output logic                          err
);

   import procPkg::*;

   ifIdT             ifD, ifQ;
   idExT             idD, idQ;
   exMemT            exD, exQ;
   memWbT            memD, memQ;
   logic             stall;
   logic             redirect;
   logic [dataW-1:0] redirectPc;
   logic             stopFetch;
   logic             squash;

   // Younger instructions die on a taken branch, a jump or a stop
   assign squash = redirect || stopFetch;

   fetchStage fetch (
      .clk        (clk),
      .rstN       (rstN),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .stopFetch  (stopFetch),
      .loadEn     (loadEn),
      .loadAddr   (loadAddr),
      .loadInstr  (loadInstr),
      .ifOut      (ifD)
   );

   pipeReg #(.payloadT(ifIdT)) ifIdReg (
      .clk(clk), .rstN(rstN), .stall(stall), .flush(squash), .d(ifD), .q(ifQ)
   );

   decodeStage decode (
      .clk(clk), .rstN(rstN), .ifIn(ifQ), .wbIn(memQ), .idOut(idD),
      .halted(halted), .err(err)
   );

   hazardUnit hazard (.ifId(ifQ), .idEx(idQ), .exMem(exQ), .stall(stall));

   // A decode stall inserts a bubble into execute
   pipeReg #(.payloadT(idExT)) idExReg (
      .clk(clk), .rstN(rstN), .stall(1'b0), .flush(squash || stall), .d(idD), .q(idQ)
   );

   executeStage execute (
      .idIn(idQ), .exOut(exD), .redirect(redirect), .redirectPc(redirectPc),
      .stopFetch(stopFetch)
   );

   pipeReg #(.payloadT(exMemT)) exMemReg (
      .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(exD), .q(exQ)
   );

   memoryStage memory (.clk(clk), .exIn(exQ), .memOut(memD));

   pipeReg #(.payloadT(memWbT)) memWbReg (
      .clk(clk), .rstN(rstN), .stall(1'b0), .flush(1'b0), .d(memD), .q(memQ)
   );

   assign wbValid = memQ.valid && memQ.regWrite;
   assign wbReg   = memQ.destReg;
   assign wbData  = memQ.wbData;

   // A stopping entry is never a branch or jump
   assert property (@(posedge clk) disable iff (!rstN) !(redirect && stopFetch));

   // Nothing retires behind the stopped entry
   assert property (@(posedge clk) disable iff (!rstN) halted |-> !wbValid);

endmodule

`default_nettype wire

// File: logic/memoryStage.sv
/* Memory stage: 256-word data memory and write-back value select */
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
   input  logic           clk,
   input  procPkg::exMemT exIn,
   output procPkg::memWbT memOut
);

   import procPkg::*;

   logic [dataW-1:0]    dataMem [2**memAddrW];
   logic [memAddrW-1:0] addr;
   logic [dataW-1:0]    readData;

   // Contents survive reset, so a later program sees earlier stores
   initial begin
      for (int i = 0; i < 2**memAddrW; i++) begin
         dataMem[i] = '0;
      end
   end

   // Word addressed with the upper address bits ignored
   assign addr = exIn.aluResult[memAddrW-1:0];

   always_ff @(posedge clk) begin
      if (exIn.valid && exIn.memWrite) begin
         dataMem[addr] <= exIn.storeData;
      end
   end

   assign readData = dataMem[addr];

   assign memOut.valid    = exIn.valid;
   assign memOut.wbData   = exIn.memRead ? readData : exIn.aluResult;
   assign memOut.destReg  = exIn.destReg;
   assign memOut.regWrite = exIn.regWrite;
   assign memOut.stop     = exIn.stop;
   assign memOut.illegal  = exIn.illegal;

endmodule

`default_nettype wire

// File: logic/executeStage.sv
/* Execute stage: ALU, branch and jump resolution,
   and the fetch stop for HALT or an illegal opcode */
`timescale 1ns/1ps
`default_nettype none

module executeStage (
   input  procPkg::idExT              idIn,
   output procPkg::exMemT             exOut,
   output logic                       redirect,
   output logic [procPkg::dataW-1:0]  redirectPc,
   output logic                       stopFetch
);

   import procPkg::*;

   logic [dataW-1:0] operandB;
   logic [dataW-1:0] aluResult;
   logic             isZero;
   logic             taken;

   // Only register-register ops take the second register
   assign operandB = (idIn.op == opRtype) ? idIn.srcB : idIn.imm;

   always_comb begin
      case (idIn.aluOp)
         aluAdd:  aluResult = idIn.srcA + operandB;
         aluSub:  aluResult = idIn.srcA - operandB;
         aluXor:  aluResult = idIn.srcA ^ operandB;
         aluAnd:  aluResult = idIn.srcA & operandB;
         default: aluResult = operandB;
      endcase
   end

   assign isZero = (idIn.srcA == '0);

   always_comb begin
      taken = 1'b0;
      if (idIn.valid) begin
         case (idIn.op)
            opBeqz:  taken = isZero;
            opBnez:  taken = !isZero;
            opJ:     taken = 1'b1;
            default: taken = 1'b0;
         endcase
      end
   end

   assign redirect   = taken;
   assign redirectPc = idIn.pc + 1'b1 + idIn.imm;
   assign stopFetch  = idIn.valid && (idIn.illegal || idIn.op == opHalt);

   assign exOut.valid     = idIn.valid;
   assign exOut.aluResult = aluResult;
   assign exOut.storeData = idIn.storeData;
   assign exOut.destReg   = idIn.destReg;
   assign exOut.regWrite  = idIn.regWrite;
   assign exOut.memRead   = idIn.memRead;
   assign exOut.memWrite  = idIn.memWrite;
   assign exOut.stop      = stopFetch;
   assign exOut.illegal   = idIn.illegal;

endmodule

`default_nettype wire

// File: logic/decodeStage.sv
/* Decode stage: control decode, immediate extension, register read,
   and the sticky halted and err flags fed from write-back */
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
   input  logic           clk,
   input  logic           rstN,
   input  procPkg::ifIdT  ifIn,
   input  procPkg::memWbT wbIn,
   output procPkg::idExT  idOut,
   output logic           halted,
   output logic           err
);

   import procPkg::*;

   opT                  opCode;
   funcT                funct;
   logic [dataW-1:0]    rdDataA;
   logic [dataW-1:0]    rdDataB;
   logic [dataW-1:0]    imm5Ext;
   logic [dataW-1:0]    imm8Ext;
   logic [dataW-1:0]    imm11Ext;

   assign opCode = opT'(ifIn.instr[opHi:opLo]);
   assign funct  = funcT'(ifIn.instr[funcHi:funcLo]);

   assign imm5Ext  = {{(dataW-imm5W){ifIn.instr[imm5W-1]}}, ifIn.instr[imm5W-1:0]};
   assign imm8Ext  = {{(dataW-imm8W){ifIn.instr[imm8W-1]}}, ifIn.instr[imm8W-1:0]};
   assign imm11Ext = {{(dataW-imm11W){ifIn.instr[imm11W-1]}}, ifIn.instr[imm11W-1:0]};

   regFile regs (
      .clk     (clk),
      .rstN    (rstN),
      .rdAddrA (ifIn.instr[rsHi:rsLo]),
      .rdAddrB (ifIn.instr[rtHi:rtLo]),
      .rdDataA (rdDataA),
      .rdDataB (rdDataB),
      .wrEn    (wbIn.valid && wbIn.regWrite),
      .wrAddr  (wbIn.destReg),
      .wrData  (wbIn.wbData)
   );

   always_comb begin
      idOut           = '0;
      idOut.valid     = ifIn.valid;
      idOut.pc        = ifIn.pc;
      idOut.op        = opCode;
      idOut.aluOp     = aluAdd;
      idOut.srcA      = rdDataA;
      idOut.srcB      = rdDataB;
      // Store source sits in the rt slot
      idOut.storeData = rdDataB;
      idOut.imm       = imm5Ext;
      case (opCode)
         opRtype: begin
            idOut.destReg  = ifIn.instr[rdHi:rdLo];
            idOut.regWrite = 1'b1;
            case (funct)
               fnAdd:   idOut.aluOp = aluAdd;
               fnSub:   idOut.aluOp = aluSub;
               fnXor:   idOut.aluOp = aluXor;
               default: idOut.aluOp = aluAnd;
            endcase
         end
         opAddi: begin
            idOut.destReg  = ifIn.instr[rtHi:rtLo];
            idOut.regWrite = 1'b1;
         end
         opLd: begin
            idOut.destReg  = ifIn.instr[rtHi:rtLo];
            idOut.regWrite = 1'b1;
            idOut.memRead  = 1'b1;
         end
         opSt:    idOut.memWrite = 1'b1;
         opLbi: begin
            idOut.imm      = imm8Ext;
            idOut.aluOp    = aluPassB;
            idOut.destReg  = ifIn.instr[rsHi:rsLo];
            idOut.regWrite = 1'b1;
         end
         opBeqz, opBnez: idOut.imm = imm8Ext;
         opJ:     idOut.imm = imm11Ext;
         opHalt, opNop: ;
         default: idOut.illegal = 1'b1;
      endcase
   end

   // Set when the stopped entry leaves MEM/WB, held until reset
   always_ff @(posedge clk) begin
      if (!rstN) begin
         halted <= 1'b0;
         err    <= 1'b0;
      end else if (wbIn.valid && wbIn.stop && !halted) begin
         halted <= 1'b1;
         err    <= wbIn.illegal;
      end
   end

endmodule

`default_nettype wire

// File: logic/hazardUnit.sv
/* Read-after-write hazard detection for the decode stage */
`timescale 1ns/1ps
`default_nettype none

module hazardUnit (
   input  procPkg::ifIdT  ifId,
   input  procPkg::idExT  idEx,
   input  procPkg::exMemT exMem,
   output logic           stall
);

   import procPkg::*;

   opT                  opCode;
   logic [regAddrW-1:0] rs;
   logic [regAddrW-1:0] rt;
   logic                readsRs;
   logic                readsRt;
   logic                hitEx;
   logic                hitMem;

   assign opCode = opT'(ifId.instr[opHi:opLo]);
   assign rs     = ifId.instr[rsHi:rsLo];
   assign rt     = ifId.instr[rtHi:rtLo];

   // Only sources the instruction really uses; LBI names rs as its target
   assign readsRs = opCode inside {opRtype, opAddi, opBeqz, opBnez, opSt, opLd};
   assign readsRt = opCode inside {opRtype, opSt};

   assign hitEx = idEx.valid && idEx.regWrite &&
                  ((readsRs && idEx.destReg == rs) || (readsRt && idEx.destReg == rt));
   assign hitMem = exMem.valid && exMem.regWrite &&
                   ((readsRs && exMem.destReg == rs) || (readsRt && exMem.destReg == rt));

   assign stall = ifId.valid && (hitEx || hitMem);

endmodule

`default_nettype wire

// File: logic/regFile.sv
/* Register file: eight 16-bit registers, two read ports,
   one write port with same-cycle bypass to the readers */
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [procPkg::regAddrW-1:0]  rdAddrA,
   input  logic [procPkg::regAddrW-1:0]  rdAddrB,
   output logic [procPkg::dataW-1:0]     rdDataA,
   output logic [procPkg::dataW-1:0]     rdDataB,
   input  logic                          wrEn,
   input  logic [procPkg::regAddrW-1:0]  wrAddr,
   input  logic [procPkg::dataW-1:0]     wrData
);

   import procPkg::*;

   logic [dataW-1:0] regs [2**regAddrW];

   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 2**regAddrW; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wrAddr] <= wrData;
      end
   end

   // Write-before-read so MEM/WB needs no hazard check
   assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
   assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

`default_nettype wire

// File: logic/fetchStage.sv
/* Fetch stage: program counter and 256-word instruction memory
   with a load port used while reset is held */
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic                          stall,
   input  logic                          redirect,
   input  logic [procPkg::dataW-1:0]     redirectPc,
   input  logic                          stopFetch,
   input  logic                          loadEn,
   input  logic [procPkg::memAddrW-1:0]  loadAddr,
   input  logic [procPkg::dataW-1:0]     loadInstr,
   output procPkg::ifIdT                 ifOut
);

   import procPkg::*;

   logic [dataW-1:0] instrMem [2**memAddrW];
   logic [dataW-1:0] pc;
   logic             stopped;

   always_ff @(posedge clk) begin
      if (loadEn) begin
         instrMem[loadAddr] <= loadInstr;
      end
   end

   // Stop is sticky until reset, and wins over redirect and stall
   always_ff @(posedge clk) begin
      if (!rstN) begin
         pc      <= '0;
         stopped <= 1'b0;
      end else if (stopFetch || stopped) begin
         stopped <= 1'b1;
      end else if (redirect) begin
         pc <= redirectPc;
      end else if (!stall) begin
         pc <= pc + 1'b1;
      end
   end

   assign ifOut.valid = !stopped;
   assign ifOut.pc    = pc;
   assign ifOut.instr = instrMem[pc[memAddrW-1:0]];

   // Program loading is only allowed under reset
   assert property (@(posedge clk) rstN |-> !loadEn);

endmodule

`default_nettype wire

// File: logic/pipeReg.sv
/* Stage latch for any payload type
   Holds on stall, clears to a bubble on reset or flush */
`timescale 1ns/1ps
`default_nettype none

module pipeReg #(
   parameter type payloadT = procPkg::ifIdT
) (
   input  logic    clk,
   input  logic    rstN,
   input  logic    stall,
   input  logic    flush,
   input  payloadT d,
   output payloadT q
);

   // All zeros means valid is low, so a cleared latch is a bubble
   always_ff @(posedge clk) begin
      if (!rstN || flush) begin
         q <= '0;
      end else if (!stall) begin
         q <= d;
      end
   end

   // A newly loaded valid entry must come from a valid input
   assert property (@(posedge clk) disable iff (!rstN)
      (q.valid && !$past(stall)) |-> $past(d.valid));

endmodule

`default_nettype wire

// File: logic/procPkg.sv
/* Shared definitions for the 16-bit pipelined core:
   widths, opcodes, instruction field positions and stage payloads */
`default_nettype none

package procPkg;

   localparam int dataW    = 16;
   localparam int regAddrW = 3;
   localparam int memAddrW = 8;

   // Instruction field positions
   localparam int opHi   = 15;
   localparam int opLo   = 11;
   localparam int rsHi   = 10;
   localparam int rsLo   = 8;
   localparam int rtHi   = 7;
   localparam int rtLo   = 5;
   localparam int rdHi   = 4;
   localparam int rdLo   = 2;
   localparam int funcHi = 1;
   localparam int funcLo = 0;

   // Immediate widths, all right aligned in the word
   localparam int imm5W  = 5;
   localparam int imm8W  = 8;
   localparam int imm11W = 11;

   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opAddi  = 5'b01000,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opLbi   = 5'b11000,
      opRtype = 5'b11011
   } opT;

   typedef enum logic [1:0] {fnAdd, fnSub, fnXor, fnAnd} funcT;

   typedef enum logic [2:0] {aluAdd, aluSub, aluXor, aluAnd, aluPassB} aluOpT;

   typedef struct packed {
      logic               valid;
      logic [dataW-1:0]   pc;
      logic [dataW-1:0]   instr;
   } ifIdT;

   typedef struct packed {
      logic                valid;
      logic [dataW-1:0]    pc;
      opT                  op;
      aluOpT               aluOp;
      logic [dataW-1:0]    srcA;
      logic [dataW-1:0]    srcB;
      logic [dataW-1:0]    storeData;
      logic [dataW-1:0]    imm;
      logic [regAddrW-1:0] destReg;
      logic                regWrite;
      logic                memRead;
      logic                memWrite;
      logic                illegal;
   } idExT;

   typedef struct packed {
      logic                valid;
      logic [dataW-1:0]    aluResult;
      logic [dataW-1:0]    storeData;
      logic [regAddrW-1:0] destReg;
      logic                regWrite;
      logic                memRead;
      logic                memWrite;
      logic                stop;
      logic                illegal;
   } exMemT;

   typedef struct packed {
      logic                valid;
      logic [dataW-1:0]    wbData;
      logic [regAddrW-1:0] destReg;
      logic                regWrite;
      logic                stop;
      logic                illegal;
   } memWbT;

endpackage

`default_nettype wire
